// ==== logic/nes_host_pkg.sv ====
/*
 * shared widths and bit indices for the NES host glue
 * softcore bridge state enum, button and mapper flag types
 * expansion audio mapper list
 */

package nes_host_pkg;

    // softcore bus
    localparam int RV_ADDR_W   = 23;
    localparam int RV_DATA_W   = 32;
    localparam int RV_STRB_W   = 4;

    // half-word memory port
    localparam int HALF_W      = 16;
    localparam int HALF_ADDR_W = 20;    // softcore addr[20:2] plus word select
    localparam int BYTE_W      = 8;

    typedef enum logic [2:0] {
        RV_IDLE_REQ0,
        RV_WAIT0_REQ1,
        RV_DATA0,
        RV_WAIT1,
        RV_DATA1
    } rv_state_e;

    // NES button order, msb first: R L D U START SELECT B A
    typedef logic [7:0] nes_btn_t;
    localparam int BTN_A      = 0;
    localparam int BTN_B      = 1;
    localparam int BTN_SELECT = 2;
    localparam int BTN_START  = 3;
    localparam int BTN_U      = 4;
    localparam int BTN_D      = 5;
    localparam int BTN_L      = 6;
    localparam int BTN_R      = 7;

    typedef logic [7:0]  ds_btn_t;          // active low
    typedef logic [63:0] mapper_flags_t;    // mapper number in [7:0]

    // mappers with expansion audio
    localparam int EXT_AUDIO_CNT = 3;
    localparam logic [EXT_AUDIO_CNT-1:0][BYTE_W-1:0] EXT_AUDIO_MAPPERS = {8'd26, 8'd24, 8'd19};

endpackage

// ==== logic/rv_bus_if.sv ====
/*
 * softcore memory bus, 32-bit data with byte strobes
 * requester and bridge modports
 */

`timescale 1ns/1ps

interface rv_bus_if import nes_host_pkg::*; ();

    logic                 valid;
    logic                 ready;    // one-cycle pulse
    logic [RV_ADDR_W-1:0] addr;
    logic [RV_DATA_W-1:0] wdata;
    logic [RV_STRB_W-1:0] wstrb;    // all zero means read
    logic [RV_DATA_W-1:0] rdata;

    modport requester (
        output valid, addr, wdata, wstrb,
        input  ready, rdata
    );

    modport bridge (
        input  valid, addr, wdata, wstrb,
        output ready, rdata
    );

endinterface

// ==== logic/rv_word_bridge.sv ====
/*
 * 32-bit softcore bus to 16-bit toggle-handshake memory port
 * one or two half-word accesses per request, lower half first
 * single-half shortcuts for lower-only and upper-only writes
 */

`timescale 1ns/1ps

module rv_word_bridge import nes_host_pkg::*; (
    input  logic                   clk,
    input  logic                   sys_resetn,
    rv_bus_if.bridge               rv,
    output logic                   o_mem_req,
    output logic [HALF_ADDR_W-1:0] o_mem_addr,
    output logic [1:0]             o_mem_ds,
    output logic [HALF_W-1:0]      o_mem_din,
    output logic                   o_mem_we,
    input  logic                   i_mem_ack,
    input  logic [HALF_W-1:0]      i_mem_dout
);

    rv_state_e         state;
    logic              valid_r;
    logic              pending;     // one remembered request
    logic              mem_req;
    logic              mem_we;
    logic              word;        // 0 lower half, 1 upper half
    logic [1:0]        ds;
    logic              ready;
    logic [HALF_W-1:0] lo_half;

    logic rise;
    logic write;
    logic ack_match;

    assign rise      = rv.valid & ~valid_r;
    assign write     = |rv.wstrb;
    assign ack_match = (mem_req == i_mem_ack);

    ////////////////////////////////////////////////////////////////////////////
    // request sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state   <= RV_IDLE_REQ0;
            valid_r <= 1'b0;
            pending <= 1'b0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            word    <= 1'b0;
            ds      <= 2'b11;
            ready   <= 1'b0;
        end else begin
            valid_r <= rv.valid;
            ready   <= 1'b0;
            if (rise)
                pending <= 1'b1;

            case (state)
                RV_IDLE_REQ0: begin
                    if (pending || rise) begin
                        pending <= 1'b0;
                        mem_req <= ~mem_req;
                        mem_we  <= write;
                        if (write && rv.wstrb[1:0] == 2'b00) begin
                            word  <= 1'b1;              // upper only
                            ds    <= rv.wstrb[3:2];
                            state <= RV_WAIT1;
                        end else begin
                            word  <= 1'b0;
                            ds    <= write ? rv.wstrb[1:0] : 2'b11;
                            state <= RV_WAIT0_REQ1;
                        end
                    end
                end
                RV_WAIT0_REQ1: begin
                    if (ack_match) begin
                        if (write && rv.wstrb[3:2] == 2'b00) begin
                            ready <= 1'b1;              // lower only, done
                            state <= RV_IDLE_REQ0;
                        end else begin
                            mem_req <= ~mem_req;        // second access
                            word    <= 1'b1;
                            ds      <= write ? rv.wstrb[3:2] : 2'b11;
                            state   <= write ? RV_WAIT1 : RV_DATA0;
                        end
                    end
                end
                RV_DATA0: state <= RV_WAIT1;            // lower half already held
                RV_WAIT1: begin
                    if (ack_match) begin
                        ready <= write;
                        state <= write ? RV_IDLE_REQ0 : RV_DATA1;
                    end
                end
                RV_DATA1: begin
                    ready <= 1'b1;
                    state <= RV_IDLE_REQ0;
                end
                default: state <= RV_IDLE_REQ0;
            endcase
        end
    end

    // lower read half, kept until the upper half comes back
    always_ff @(posedge clk) begin
        if (state == RV_WAIT0_REQ1 && ack_match && !write)
            lo_half <= i_mem_dout;
    end

    assign o_mem_req  = mem_req;
    assign o_mem_we   = mem_we;
    assign o_mem_ds   = ds;
    assign o_mem_addr = {rv.addr[HALF_ADDR_W:2], word};
    assign o_mem_din  = word ? rv.wdata[RV_DATA_W-1:HALF_W] : rv.wdata[HALF_W-1:0];

    assign rv.ready = ready;
    assign rv.rdata = {i_mem_dout, lo_half};   // upper half stable until next toggle

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_ready_pulse : assert property (@(posedge clk) disable iff (!sys_resetn)
        ready |=> !ready);

    // no new toggle while the memory still owes an ack
    a_req_hold : assert property (@(posedge clk) disable iff (!sys_resetn)
        (mem_req != i_mem_ack) |=> $stable(mem_req));

endmodule

// ==== logic/joypad_port.sv ====
/*
 * one NES controller port
 * DualShock bytes to NES buttons, ORed with the gamepad state
 * serial shift register read by the NES core
 */

`timescale 1ns/1ps

module joypad_port import nes_host_pkg::*; (
    input  logic     clk,
    input  logic     sys_resetn,
    input  ds_btn_t  i_ds_byte0,    // L D R U St R3 L3 Se
    input  ds_btn_t  i_ds_byte1,    // sq X O tri R1 L1 R2 L2
    input  nes_btn_t i_pad_state,
    input  logic     i_strobe,
    input  logic     i_pad_clock,
    output logic     o_pad_data,
    output nes_btn_t o_buttons
);

    nes_btn_t ds_map;
    nes_btn_t shift_q;
    logic     pad_clock_r;
    logic     pad_fall;

    // circle is A, cross is B
    always_comb begin
        ds_map             = '0;
        ds_map[BTN_R]      = ~i_ds_byte0[5];
        ds_map[BTN_L]      = ~i_ds_byte0[7];
        ds_map[BTN_D]      = ~i_ds_byte0[6];
        ds_map[BTN_U]      = ~i_ds_byte0[4];
        ds_map[BTN_START]  = ~i_ds_byte0[3];
        ds_map[BTN_SELECT] = ~i_ds_byte0[0];
        ds_map[BTN_B]      = ~i_ds_byte1[6];
        ds_map[BTN_A]      = ~i_ds_byte1[5];
    end

    assign o_buttons = ds_map | i_pad_state;
    assign pad_fall  = ~i_pad_clock & pad_clock_r;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            pad_clock_r <= 1'b0;
            shift_q     <= '0;
        end else begin
            pad_clock_r <= i_pad_clock;
            if (i_strobe)
                shift_q <= o_buttons;                  // keep reloading while strobed
            else if (pad_fall)
                shift_q <= {1'b1, shift_q[7:1]};       // A goes out first
        end
    end

    assign o_pad_data = shift_q[0];

endmodule

// ==== logic/rom_load_ctrl.sv ====
/*
 * cartridge load control
 * loader write stretch and capture, CPU/loader byte port mux
 * NES reset, clock reference, mapper flags and expansion audio
 */

`timescale 1ns/1ps

module rom_load_ctrl import nes_host_pkg::*; #(
    parameter int MEM_ADDR_W = 22
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_loading,
    input  logic                  i_loader_write,
    input  logic [MEM_ADDR_W-1:0] i_loader_addr,
    input  logic [BYTE_W-1:0]     i_loader_data,
    input  logic                  i_loader_done,
    input  mapper_flags_t         i_loader_flags,
    input  logic [MEM_ADDR_W-1:0] i_cpu_addr,
    input  logic                  i_cpu_read,
    input  logic                  i_cpu_write,
    input  logic [BYTE_W-1:0]     i_cpu_dout,
    output logic [MEM_ADDR_W-1:0] o_memb_addr,
    output logic                  o_memb_we,
    output logic [BYTE_W-1:0]     o_memb_din,
    output logic                  o_memb_oe,
    output logic                  o_reset_nes,
    output logic                  o_clkref,
    output logic                  o_loader_reset,
    output mapper_flags_t         o_mapper_flags,
    output logic                  o_ext_audio
);

    logic                  loading_r;
    logic                  write_r;
    logic                  write_mem;   // two cycles per loader write
    logic [MEM_ADDR_W-1:0] addr_q;
    logic [BYTE_W-1:0]     data_q;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r      <= 1'b0;
            write_r        <= 1'b0;
            write_mem      <= 1'b0;
            o_reset_nes    <= 1'b1;
            o_clkref       <= 1'b0;
            o_mapper_flags <= '0;
        end else begin
            loading_r <= i_loading;
            write_r   <= i_loader_write;
            write_mem <= i_loader_write | write_r;
            o_clkref  <= ~o_clkref;
            if (i_loader_done)
                o_mapper_flags <= i_loader_flags;
            if (!i_loading && loading_r) begin
                o_reset_nes <= 1'b0;             // release the core
                o_clkref    <= 1'b1;
            end else if (i_loading && !loading_r) begin
                o_reset_nes <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_loader_write) begin
            addr_q <= i_loader_addr;
            data_q <= i_loader_data;
        end
    end

    assign o_loader_reset = i_loading & ~loading_r;

    ////////////////////////////////////////////////////////////////////////////
    // byte port B and expansion audio
    ////////////////////////////////////////////////////////////////////////////

    assign o_memb_addr = i_loading ? addr_q : i_cpu_addr;
    assign o_memb_din  = i_loading ? data_q : i_cpu_dout;
    assign o_memb_we   = write_mem | i_cpu_write;
    assign o_memb_oe   = ~i_loading & i_cpu_read;

    always_comb begin
        o_ext_audio = 1'b0;
        for (int i = 0; i < EXT_AUDIO_CNT; i++) begin
            if (o_mapper_flags[BYTE_W-1:0] == EXT_AUDIO_MAPPERS[i])
                o_ext_audio = 1'b1;
        end
    end

    // core held in reset for the whole load
    a_reset_while_loading : assert property (@(posedge clk) disable iff (!sys_resetn)
        i_loading && loading_r |-> o_reset_nes);

endmodule

// ==== logic/nes_host_top.sv ====
/*
 * NES host glue top level
 * softcore bridge, two joypad ports and cartridge load control
 */

`timescale 1ns/1ps

module nes_host_top import nes_host_pkg::*; #(
    parameter int MEM_ADDR_W = 22
) (
    input  logic                   clk,
    input  logic                   sys_resetn,
    // softcore bus
    input  logic                   i_rv_valid,
    input  logic [RV_ADDR_W-1:0]   i_rv_addr,
    input  logic [RV_DATA_W-1:0]   i_rv_wdata,
    input  logic [RV_STRB_W-1:0]   i_rv_wstrb,
    output logic                   o_rv_ready,
    output logic [RV_DATA_W-1:0]   o_rv_rdata,
    // half-word memory port
    output logic                   o_mem_req,
    output logic [HALF_ADDR_W-1:0] o_mem_addr,
    output logic [1:0]             o_mem_ds,
    output logic [HALF_W-1:0]      o_mem_din,
    output logic                   o_mem_we,
    input  logic                   i_mem_ack,
    input  logic [HALF_W-1:0]      i_mem_dout,
    // loader and CPU side
    input  logic                   i_loading,
    input  logic                   i_loader_write,
    input  logic [MEM_ADDR_W-1:0]  i_loader_addr,
    input  logic [BYTE_W-1:0]      i_loader_data,
    input  logic                   i_loader_done,
    input  mapper_flags_t          i_loader_flags,
    input  logic [MEM_ADDR_W-1:0]  i_cpu_addr,
    input  logic                   i_cpu_read,
    input  logic                   i_cpu_write,
    input  logic [BYTE_W-1:0]      i_cpu_dout,
    output logic [MEM_ADDR_W-1:0]  o_memb_addr,
    output logic                   o_memb_we,
    output logic [BYTE_W-1:0]      o_memb_din,
    output logic                   o_memb_oe,
    output logic                   o_reset_nes,
    output logic                   o_clkref,
    output logic                   o_loader_reset,
    output mapper_flags_t          o_mapper_flags,
    output logic                   o_ext_audio,
    // controllers
    input  ds_btn_t                i_ds1_byte0,
    input  ds_btn_t                i_ds1_byte1,
    input  nes_btn_t               i_pad1_state,
    input  logic                   i_pad_clock1,
    output logic                   o_pad1_data,
    output nes_btn_t               o_buttons1,
    input  ds_btn_t                i_ds2_byte0,
    input  ds_btn_t                i_ds2_byte1,
    input  nes_btn_t               i_pad2_state,
    input  logic                   i_pad_clock2,
    output logic                   o_pad2_data,
    output nes_btn_t               o_buttons2,
    input  logic                   i_joypad_strobe
);

    rv_bus_if u_rv_bus ();

    // requester side comes straight from the top ports
    assign u_rv_bus.valid = i_rv_valid;
    assign u_rv_bus.addr  = i_rv_addr;
    assign u_rv_bus.wdata = i_rv_wdata;
    assign u_rv_bus.wstrb = i_rv_wstrb;
    assign o_rv_ready     = u_rv_bus.ready;
    assign o_rv_rdata     = u_rv_bus.rdata;

    rv_word_bridge u_bridge (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .rv         (u_rv_bus.bridge),
        .o_mem_req  (o_mem_req),
        .o_mem_addr (o_mem_addr),
        .o_mem_ds   (o_mem_ds),
        .o_mem_din  (o_mem_din),
        .o_mem_we   (o_mem_we),
        .i_mem_ack  (i_mem_ack),
        .i_mem_dout (i_mem_dout)
    );

    joypad_port u_pad1 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_ds_byte0  (i_ds1_byte0),
        .i_ds_byte1  (i_ds1_byte1),
        .i_pad_state (i_pad1_state),
        .i_strobe    (i_joypad_strobe),
        .i_pad_clock (i_pad_clock1),
        .o_pad_data  (o_pad1_data),
        .o_buttons   (o_buttons1)
    );

    joypad_port u_pad2 (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_ds_byte0  (i_ds2_byte0),
        .i_ds_byte1  (i_ds2_byte1),
        .i_pad_state (i_pad2_state),
        .i_strobe    (i_joypad_strobe),
        .i_pad_clock (i_pad_clock2),
        .o_pad_data  (o_pad2_data),
        .o_buttons   (o_buttons2)
    );

    rom_load_ctrl #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_load (
        .clk            (clk),
        .sys_resetn     (sys_resetn),
        .i_loading      (i_loading),
        .i_loader_write (i_loader_write),
        .i_loader_addr  (i_loader_addr),
        .i_loader_data  (i_loader_data),
        .i_loader_done  (i_loader_done),
        .i_loader_flags (i_loader_flags),
        .i_cpu_addr     (i_cpu_addr),
        .i_cpu_read     (i_cpu_read),
        .i_cpu_write    (i_cpu_write),
        .i_cpu_dout     (i_cpu_dout),
        .o_memb_addr    (o_memb_addr),
        .o_memb_we      (o_memb_we),
        .o_memb_din     (o_memb_din),
        .o_memb_oe      (o_memb_oe),
        .o_reset_nes    (o_reset_nes),
        .o_clkref       (o_clkref),
        .o_loader_reset (o_loader_reset),
        .o_mapper_flags (o_mapper_flags),
        .o_ext_audio    (o_ext_audio)
    );

endmodule

// ==== dv/tb_checks.svh ====
/*
 * testbench helpers for the NES host glue
 * compare tasks, softcore bus driver, ready wait with timeout
 * memory access log check
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int READY_TIMEOUT = 200;     // cycles

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_word(input string name, input logic [RV_DATA_W-1:0] exp,
                          input logic [RV_DATA_W-1:0] act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_half(input string name, input logic [HALF_W-1:0] exp,
                          input logic [HALF_W-1:0] act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                          input logic [BYTE_W-1:0] act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_buttons(input string name, input nes_btn_t exp, input nes_btn_t act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_flags(input string name, input mapper_flags_t exp,
                           input mapper_flags_t act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end_with_failure();
    end
endtask

////////////////////////////////////////////////////////////////////////////
// softcore bus
////////////////////////////////////////////////////////////////////////////

// ready and rdata sampled mid-cycle
task automatic wait_ready(output logic [RV_DATA_W-1:0] rdata);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > READY_TIMEOUT) begin
            $display("timeout waiting for ready on the softcore bus");
            end_with_failure();
        end
    end while (!o_rv_ready);
    rdata = o_rv_rdata;
endtask

task automatic rv_access(
    input  logic [RV_ADDR_W-1:0] addr,
    input  logic [RV_DATA_W-1:0] wdata,
    input  logic [RV_STRB_W-1:0] wstrb,   // zero for a read
    output logic [RV_DATA_W-1:0] rdata
);
    @(posedge clk);
    i_rv_valid <= 1'b1;
    i_rv_addr  <= addr;
    i_rv_wdata <= wdata;
    i_rv_wstrb <= wstrb;
    wait_ready(rdata);
    @(posedge clk);
    i_rv_valid <= 1'b0;     // held until after the ready cycle
endtask

task automatic clear_log();
    log_addr.delete();
    log_ds.delete();
    log_we.delete();
    log_din.delete();
endtask

// expected accesses with the lower half first and none for a half without strobes
task automatic check_log(input logic [RV_ADDR_W-1:0] addr, input logic [RV_DATA_W-1:0] wdata,
                         input logic [RV_STRB_W-1:0] wstrb);
    logic [HALF_ADDR_W-1:0] exp_addr [$];
    logic [1:0]             exp_ds [$];
    logic [HALF_W-1:0]      exp_din [$];
    logic                   is_write;
    is_write = |wstrb;
    if (!is_write || wstrb[1:0] != 2'b00) begin
        exp_addr.push_back({addr[HALF_ADDR_W:2], 1'b0});
        exp_ds.push_back(is_write ? wstrb[1:0] : 2'b11);
        exp_din.push_back(wdata[HALF_W-1:0]);
    end
    if (!is_write || wstrb[3:2] != 2'b00) begin
        exp_addr.push_back({addr[HALF_ADDR_W:2], 1'b1});
        exp_ds.push_back(is_write ? wstrb[3:2] : 2'b11);
        exp_din.push_back(wdata[RV_DATA_W-1:HALF_W]);
    end
    check_word("memory access count", exp_addr.size(), log_addr.size());
    foreach (exp_addr[i]) begin
        check_word("o_mem_addr", exp_addr[i], log_addr[i]);
        check_byte("o_mem_ds", exp_ds[i], log_ds[i]);
        check_bit("o_mem_we", is_write, log_we[i]);
        if (is_write)
            check_half("o_mem_din", exp_din[i], log_din[i]);
    end
endtask

`endif

// ==== dv/tb_nes_host_top.sv ====
/*
 * testbench for the NES host glue top level
 * clock and reset, half-word memory model on the toggle port
 * directed tests for bridge, load control and joypads
 */

`timescale 1ns/1ps

module tb_nes_host_top import nes_host_pkg::*; ();

    localparam int MEM_ADDR_W = 22;

    logic                   clk;
    logic                   sys_resetn;
    logic                   i_rv_valid;
    logic [RV_ADDR_W-1:0]   i_rv_addr;
    logic [RV_DATA_W-1:0]   i_rv_wdata;
    logic [RV_STRB_W-1:0]   i_rv_wstrb;
    logic                   o_rv_ready;
    logic [RV_DATA_W-1:0]   o_rv_rdata;
    logic                   o_mem_req;
    logic [HALF_ADDR_W-1:0] o_mem_addr;
    logic [1:0]             o_mem_ds;
    logic [HALF_W-1:0]      o_mem_din;
    logic                   o_mem_we;
    logic                   i_mem_ack;
    logic [HALF_W-1:0]      i_mem_dout;
    logic                   i_loading;
    logic                   i_loader_write;
    logic [MEM_ADDR_W-1:0]  i_loader_addr;
    logic [BYTE_W-1:0]      i_loader_data;
    logic                   i_loader_done;
    mapper_flags_t          i_loader_flags;
    logic [MEM_ADDR_W-1:0]  i_cpu_addr;
    logic                   i_cpu_read;
    logic                   i_cpu_write;
    logic [BYTE_W-1:0]      i_cpu_dout;
    logic [MEM_ADDR_W-1:0]  o_memb_addr;
    logic                   o_memb_we;
    logic [BYTE_W-1:0]      o_memb_din;
    logic                   o_memb_oe;
    logic                   o_reset_nes;
    logic                   o_clkref;
    logic                   o_loader_reset;
    mapper_flags_t          o_mapper_flags;
    logic                   o_ext_audio;
    ds_btn_t                i_ds1_byte0;
    ds_btn_t                i_ds1_byte1;
    nes_btn_t               i_pad1_state;
    logic                   i_pad_clock1;
    logic                   o_pad1_data;
    nes_btn_t               o_buttons1;
    ds_btn_t                i_ds2_byte0;
    ds_btn_t                i_ds2_byte1;
    nes_btn_t               i_pad2_state;
    logic                   i_pad_clock2;
    logic                   o_pad2_data;
    nes_btn_t               o_buttons2;
    logic                   i_joypad_strobe;

    int seed = 44497;

    // memory model and a log of every access it served
    logic [HALF_W-1:0]      mem_model [0:(1<<HALF_ADDR_W)-1];
    logic [HALF_ADDR_W-1:0] log_addr [$];
    logic [1:0]             log_ds [$];
    logic                   log_we [$];
    logic [HALF_W-1:0]      log_din [$];

    `include "tb_checks.svh"

    nes_host_top #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) i_dut (.*);

    always #10 clk = ~clk;

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [HALF_W-1:0] fill_half(input logic [HALF_ADDR_W-1:0] a);
        fill_half = a[15:0] ^ {4{a[19:16]}} ^ 16'h3c5a;
    endfunction

    // upper half then lower half from the model
    function automatic logic [RV_DATA_W-1:0] model_word(input logic [RV_ADDR_W-1:0] a);
        model_word = {mem_model[{a[HALF_ADDR_W:2], 1'b1}], mem_model[{a[HALF_ADDR_W:2], 1'b0}]};
    endfunction

    // answers each toggle after 1 to 4 cycles
    always begin : mem_responder
        int                     delay;
        logic [HALF_ADDR_W-1:0] a;
        @(posedge clk);
        if (sys_resetn && (o_mem_req != i_mem_ack)) begin
            delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (delay - 1) @(posedge clk);
            a = o_mem_addr;
            log_addr.push_back(a);
            log_ds.push_back(o_mem_ds);
            log_we.push_back(o_mem_we);
            log_din.push_back(o_mem_din);
            if (o_mem_we && o_mem_ds[0])
                mem_model[a][7:0] = o_mem_din[7:0];
            if (o_mem_we && o_mem_ds[1])
                mem_model[a][15:8] = o_mem_din[15:8];
            i_mem_dout <= mem_model[a];     // held until the next toggle
            i_mem_ack  <= o_mem_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [RV_DATA_W-1:0] merge_bytes(input logic [RV_DATA_W-1:0] old,
                                                         input logic [RV_DATA_W-1:0] wdata,
                                                         input logic [RV_STRB_W-1:0] wstrb);
        merge_bytes = old;
        for (int i = 0; i < RV_STRB_W; i++) begin
            if (wstrb[i])
                merge_bytes[i*BYTE_W +: BYTE_W] = wdata[i*BYTE_W +: BYTE_W];
        end
    endfunction

    // R L D U START SELECT B A from the active-low pad bytes
    function automatic nes_btn_t expect_buttons(input ds_btn_t b0, input ds_btn_t b1,
                                                input nes_btn_t state);
        expect_buttons = ~{b0[5], b0[7], b0[6], b0[4], b0[3], b0[0], b1[6], b1[5]} | state;
    endfunction

    task automatic init_inputs();
        sys_resetn      = 1'b0;
        i_rv_valid      = 1'b0;
        i_rv_addr       = '0;
        i_rv_wdata      = '0;
        i_rv_wstrb      = '0;
        i_mem_ack       = 1'b0;
        i_mem_dout      = '0;
        i_loading       = 1'b0;
        i_loader_write  = 1'b0;
        i_loader_addr   = '0;
        i_loader_data   = '0;
        i_loader_done   = 1'b0;
        i_loader_flags  = '0;
        i_cpu_addr      = '0;
        i_cpu_read      = 1'b0;
        i_cpu_write     = 1'b0;
        i_cpu_dout      = '0;
        i_ds1_byte0     = 8'hff;        // nothing pressed
        i_ds1_byte1     = 8'hff;
        i_pad1_state    = '0;
        i_pad_clock1    = 1'b0;
        i_ds2_byte0     = 8'hff;
        i_ds2_byte1     = 8'hff;
        i_pad2_state    = '0;
        i_pad_clock2    = 1'b0;
        i_joypad_strobe = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        @(negedge clk);
        check_bit("o_rv_ready", 1'b0, o_rv_ready);
        check_bit("o_memb_we", 1'b0, o_memb_we);
        check_bit("o_mem_we", 1'b0, o_mem_we);
        check_bit("o_mem_req", 1'b0, o_mem_req);
        check_bit("o_reset_nes", 1'b1, o_reset_nes);
    endtask

    task automatic test_read();
        logic [RV_ADDR_W-1:0] addr;
        logic [RV_DATA_W-1:0] exp;
        logic [RV_DATA_W-1:0] rdata;
        for (int n = 0; n < 6; n++) begin
            addr = $random(seed);
            exp  = model_word(addr);
            clear_log();
            rv_access(addr, $random(seed), '0, rdata);
            check_log(addr, '0, '0);
            check_word("o_rv_rdata", exp, rdata);
        end
    endtask

    task automatic test_writes();
        logic [RV_STRB_W-1:0] strobes [4];
        logic [RV_ADDR_W-1:0] addr;
        logic [RV_DATA_W-1:0] wdata;
        logic [RV_DATA_W-1:0] exp;
        logic [RV_DATA_W-1:0] rdata;
        strobes = '{4'b1111, 4'b0011, 4'b1100, 4'b0100};
        foreach (strobes[s]) begin
            addr  = $random(seed);
            wdata = $random(seed);
            exp   = merge_bytes(model_word(addr), wdata, strobes[s]);
            clear_log();
            rv_access(addr, wdata, strobes[s], rdata);
            check_log(addr, wdata, strobes[s]);
            clear_log();
            rv_access(addr, '0, '0, rdata);     // read back
            check_word("o_rv_rdata", exp, rdata);
        end
    endtask

    task automatic check_port_b(input logic exp_we, input logic [MEM_ADDR_W-1:0] addr,
                                input logic [BYTE_W-1:0] data);
        @(negedge clk);
        check_bit("o_memb_we", exp_we, o_memb_we);
        check_bit("o_memb_oe", 1'b0, o_memb_oe);
        if (exp_we) begin
            check_word("o_memb_addr", addr, o_memb_addr);
            check_byte("o_memb_din", data, o_memb_din);
        end
    endtask

    task automatic pulse_done(input mapper_flags_t flags);
        @(posedge clk);
        i_loader_done  <= 1'b1;
        i_loader_flags <= flags;
        @(posedge clk);
        i_loader_done  <= 1'b0;
        @(negedge clk);
        check_flags("o_mapper_flags", flags, o_mapper_flags);
    endtask

    task automatic test_loading();
        logic [MEM_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     data;
        mapper_flags_t         flags;
        @(posedge clk);
        i_loading  <= 1'b1;
        i_cpu_read <= 1'b1;     // must stay blocked
        @(negedge clk);
        check_bit("o_loader_reset", 1'b1, o_loader_reset);
        for (int n = 0; n < 3; n++) begin
            addr = $random(seed);
            data = $random(seed);
            @(posedge clk);
            i_loader_write <= 1'b1;
            i_loader_addr  <= addr;
            i_loader_data  <= data;
            check_port_b(1'b0, addr, data);
            @(posedge clk);
            i_loader_write <= 1'b0;
            i_loader_addr  <= ~addr;    // port B shows the captured values
            i_loader_data  <= ~data;
            check_port_b(1'b1, addr, data);
            check_port_b(1'b1, addr, data);
            check_port_b(1'b0, addr, data);
        end
        flags       = {$random(seed), $random(seed)};
        flags[7:0]  = 8'd24;
        pulse_done(flags);
        check_bit("o_ext_audio", 1'b1, o_ext_audio);
        flags[7:0]  = 8'd4;
        pulse_done(flags);
        check_bit("o_ext_audio", 1'b0, o_ext_audio);
        @(posedge clk);
        i_loading <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("o_reset_nes", 1'b0, o_reset_nes);
        check_bit("o_clkref", 1'b1, o_clkref);
        check_bit("o_memb_oe", 1'b1, o_memb_oe);
        @(posedge clk);
        i_cpu_read <= 1'b0;
        @(negedge clk);
        check_bit("o_clkref", 1'b0, o_clkref);     // toggling again
    endtask

    // one pad clock pulse and the cycles until the shift is visible
    task automatic clock_pad(input int pad);
        @(posedge clk);
        if (pad == 1)
            i_pad_clock1 <= 1'b1;
        else
            i_pad_clock2 <= 1'b1;
        @(posedge clk);
        if (pad == 1)
            i_pad_clock1 <= 1'b0;
        else
            i_pad_clock2 <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic test_joypads();
        nes_btn_t exp1;
        nes_btn_t exp2;
        for (int n = 0; n < 5; n++) begin
            @(posedge clk);
            i_ds1_byte0  <= $random(seed);
            i_ds1_byte1  <= $random(seed);
            i_pad1_state <= $random(seed) & $random(seed) & $random(seed);
            i_ds2_byte0  <= $random(seed);
            i_ds2_byte1  <= $random(seed);
            i_pad2_state <= $random(seed) & $random(seed) & $random(seed);
            @(negedge clk);
            exp1 = expect_buttons(i_ds1_byte0, i_ds1_byte1, i_pad1_state);
            exp2 = expect_buttons(i_ds2_byte0, i_ds2_byte1, i_pad2_state);
            check_buttons("o_buttons1", exp1, o_buttons1);
            check_buttons("o_buttons2", exp2, o_buttons2);
        end
        @(posedge clk);
        i_joypad_strobe <= 1'b1;
        @(posedge clk);
        i_joypad_strobe <= 1'b0;
        @(negedge clk);
        // A first, then B SELECT START U D L R, then ones
        for (int i = 0; i < 10; i++) begin
            check_bit("o_pad1_data", (i < 8) ? exp1[i] : 1'b1, o_pad1_data);
            check_bit("o_pad2_data", exp2[0], o_pad2_data);
            clock_pad(1);
        end
        for (int i = 0; i < 9; i++) begin
            check_bit("o_pad2_data", (i < 8) ? exp2[i] : 1'b1, o_pad2_data);
            check_bit("o_pad1_data", 1'b1, o_pad1_data);
            clock_pad(2);
        end
    endtask

    initial begin
        clk = 1'b0;
        init_inputs();
        for (int a = 0; a < (1 << HALF_ADDR_W); a++)
            mem_model[a] = fill_half(a[HALF_ADDR_W-1:0]);
        repeat (16) @(posedge clk);
        sys_resetn <= 1'b1;
        test_reset_values();
        test_read();
        test_writes();
        test_loading();
        test_joypads();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== nes_host_top.f ====
+incdir+dv
logic/nes_host_pkg.sv
logic/rv_bus_if.sv
logic/rv_word_bridge.sv
logic/joypad_port.sv
logic/rom_load_ctrl.sv
logic/nes_host_top.sv
dv/tb_nes_host_top.sv
